//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_mv_search
RTL_TOP   ?= mv_search_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

RTL_FILES := $(shell grep '^rtl/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass message in log"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/best_match.sv
`timescale 1ns/1ps

module best_match import me_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic block_done,
	input  sad_t sads [NUM_CAND],
	output logic busy,
	output logic out_valid,
	output mv_t  mv,
	output sad_t sad,
	input  logic out_credit
);

	match_state_t         state;
	mv_t                  idx;
	mv_t                  best_mv;
	sad_t                 best_sad;
	logic [OUT_CNT_W-1:0] credits;
	logic                 send;
	logic                 scan_last;

	// block_done already counts as busy so the feeder cannot pop in that cycle
	assign busy = block_done || (state != IDLE);

	assign send      = (state == SEND) && (credits != '0);
	assign scan_last = (idx == mv_t'(NUM_CAND - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			idx   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (block_done) begin
						state <= SCAN;
						idx   <= '0;
					end
				end
				SCAN: begin
					idx <= idx + 1'b1;
					if (scan_last) begin
						state <= SEND;
					end
				end
				SEND: begin
					// waits here for as long as the sink holds back credits
					if (send) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// strict compare keeps the lowest index on a tie
	always_ff @(posedge clk) begin
		if (state == SCAN) begin
			if ((idx == '0) || (sads[idx] < best_sad)) begin
				best_sad <= sads[idx];
				best_mv  <= idx;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= OUT_CNT_W'(OUT_CREDITS);
		end else begin
			credits <= credits + OUT_CNT_W'(out_credit) - OUT_CNT_W'(send);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= send;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			mv  <= best_mv;
			sad <= best_sad;
		end
	end

	// sink returns no more credits than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= OUT_CNT_W'(OUT_CREDITS));

	// feeder stalls on busy, so a new block cannot finish mid-drain
	a_done_idle: assert property (@(posedge clk) disable iff (!arst_n)
		block_done |-> (state == IDLE));

endmodule

//--- rtl/me_pkg.sv
package me_pkg;

	// search geometry
	localparam int NUM_CAND        = 16;
	localparam int BLOCK_PIXELS    = 256;
	localparam int BEATS_PER_BLOCK = BLOCK_PIXELS + NUM_CAND - 1;

	// credit pools on both sides
	localparam int IN_CREDITS  = 4;
	localparam int OUT_CREDITS = 2;

	// input FIFO addressing and occupancy
	localparam int IN_PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
	localparam int IN_CNT_W = $clog2(IN_CREDITS + 1);

	// output credit counter has to hold OUT_CREDITS itself
	localparam int OUT_CNT_W = $clog2(OUT_CREDITS + 1);

	// one luma sample
	typedef logic [7:0] pixel_t;

	// 256 * 255 = 65280 fits in 16 bits
	typedef logic [15:0] sad_t;

	// candidate index 0..15
	typedef logic [3:0] mv_t;

	// position inside the 271-beat search stream
	typedef logic [8:0] beat_t;

	// drain sequence
	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		SEND
	} match_state_t;

endpackage

//--- rtl/mv_search_top.sv
`timescale 1ns/1ps

module mv_search_top import me_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   in_valid,
	input  pixel_t c_pix,
	input  pixel_t p_pix,
	output logic   in_credit,
	output logic   out_valid,
	output mv_t    mv,
	output sad_t   sad,
	input  logic   out_credit
);

	logic   step;
	pixel_t p;
	logic   block_done;
	logic   busy;

	// c path through the chain starts with the feeder at entry 0
	pixel_t            c_chain [NUM_CAND+1];
	logic [NUM_CAND:0] v_chain;
	logic [NUM_CAND:0] f_chain;
	sad_t              sads [NUM_CAND];

	pixel_feeder u_feeder (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.c_pix      (c_pix),
		.p_pix      (p_pix),
		.in_credit  (in_credit),
		.busy       (busy),
		.step       (step),
		.c          (c_chain[0]),
		.c_valid    (v_chain[0]),
		.c_first    (f_chain[0]),
		.p          (p),
		.block_done (block_done)
	);

	// PE d sees c delayed by d steps against the broadcast p
	for (genvar d = 0; d < NUM_CAND; d++) begin : g_pe
		sad_pe u_pe (
			.clk         (clk),
			.arst_n      (arst_n),
			.step        (step),
			.c_in        (c_chain[d]),
			.c_valid_in  (v_chain[d]),
			.c_first_in  (f_chain[d]),
			.p           (p),
			.c_out       (c_chain[d+1]),
			.c_valid_out (v_chain[d+1]),
			.c_first_out (f_chain[d+1]),
			.sad         (sads[d])
		);
	end

	best_match u_drain (
		.clk        (clk),
		.arst_n     (arst_n),
		.block_done (block_done),
		.sads       (sads),
		.busy       (busy),
		.out_valid  (out_valid),
		.mv         (mv),
		.sad        (sad),
		.out_credit (out_credit)
	);

endmodule

//--- rtl/pixel_feeder.sv
`timescale 1ns/1ps

module pixel_feeder import me_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   in_valid,
	input  pixel_t c_pix,
	input  pixel_t p_pix,
	output logic   in_credit,
	input  logic   busy,
	output logic   step,
	output pixel_t c,
	output logic   c_valid,
	output logic   c_first,
	output pixel_t p,
	output logic   block_done
);

	// one slot per credit handed to the source
	pixel_t mem_c [IN_CREDITS];
	pixel_t mem_p [IN_CREDITS];

	logic [IN_PTR_W-1:0] wr_ptr;
	logic [IN_PTR_W-1:0] rd_ptr;
	logic [IN_CNT_W-1:0] fill;
	logic                empty;
	logic                pop;
	beat_t               beat;
	logic                last_beat;

	assign empty = (fill == '0);

	// hold the stream while the drain reads the accumulators
	assign pop = !empty && !busy;

	assign step      = pop;
	assign in_credit = pop;

	assign c = mem_c[rd_ptr];
	assign p = mem_p[rd_ptr];

	assign last_beat = (beat == beat_t'(BEATS_PER_BLOCK - 1));

	// only the first 256 beats carry current-block pixels
	assign c_valid = (beat < beat_t'(BLOCK_PIXELS));
	assign c_first = (beat == '0);

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem_c[wr_ptr] <= c_pix;
			mem_p[wr_ptr] <= p_pix;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
		end else if (in_valid) begin
			if (wr_ptr == IN_PTR_W'(IN_CREDITS - 1)) begin
				wr_ptr <= '0;
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
		end else if (pop) begin
			if (rd_ptr == IN_PTR_W'(IN_CREDITS - 1)) begin
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fill <= '0;
		end else begin
			case ({in_valid, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// beat index wraps after the last search pixel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			beat <= '0;
		end else if (pop) begin
			beat <= last_beat ? '0 : beat + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			block_done <= 1'b0;
		end else begin
			block_done <= pop && last_beat;
		end
	end

	// the source sends only against a credit, so a full FIFO never sees a push
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> (fill != IN_CNT_W'(IN_CREDITS)));

endmodule

//--- rtl/sad_pe.sv
`timescale 1ns/1ps

module sad_pe import me_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   step,
	input  pixel_t c_in,
	input  logic   c_valid_in,
	input  logic   c_first_in,
	input  pixel_t p,
	output pixel_t c_out,
	output logic   c_valid_out,
	output logic   c_first_out,
	output sad_t   sad
);

	pixel_t diff;
	logic   acc_en;

	// absolute difference without a sign bit
	assign diff = (c_in > p) ? (c_in - p) : (p - c_in);

	assign acc_en = step && c_valid_in;

	// c pixel moves one PE down the chain per step
	always_ff @(posedge clk) begin
		if (step) begin
			c_out <= c_in;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			c_valid_out <= 1'b0;
			c_first_out <= 1'b0;
		end else if (step) begin
			c_valid_out <= c_valid_in;
			c_first_out <= c_first_in;
		end
	end

	// restart on the first pixel of a block, otherwise add
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sad <= '0;
		end else if (acc_en) begin
			if (c_first_in) begin
				sad <= sad_t'(diff);
			end else begin
				sad <= sad + sad_t'(diff);
			end
		end
	end

	// a block never brings more than 256 adds, so the sum only grows
	a_no_wrap: assert property (@(posedge clk) disable iff (!arst_n)
		acc_en && !c_first_in |=> sad >= $past(sad));

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// released on the 8th rising edge
	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

//--- tb/tb_mv_search.sv
`timescale 1ns/1ps

module tb_mv_search import me_pkg::*; ();

	localparam int BLOCKS_TOTAL    = 18;
	localparam int WATCHDOG_CYCLES = BLOCKS_TOTAL * BEATS_PER_BLOCK * 4 + 2000;

	logic   clk;
	logic   arst_n;
	logic   in_valid = 1'b0;
	pixel_t c_pix = '0;
	pixel_t p_pix = '0;
	logic   in_credit;
	logic   out_valid;
	mv_t    mv;
	sad_t   sad;
	logic   out_credit = 1'b0;

	integer seed = 32'hd5d0;

	pixel_t cur_c [BLOCK_PIXELS];
	pixel_t cur_p [BEATS_PER_BLOCK];
	pixel_t q_c [$];
	pixel_t q_p [$];
	mv_t    exp_mv [$];
	sad_t   exp_sad [$];
	int     planted [4] = '{0, 5, 9, 15};

	int   errors = 0;
	int   errors_at_start = 0;
	int   tests_run = 0;
	int   tests_failed = 0;
	int   beats_sent = 0;
	int   credit_pulses = 0;
	int   results_seen = 0;
	int   allowed_results = 32'h7fffffff;
	int   src_credits = IN_CREDITS;
	int   mon_credits = IN_CREDITS;
	int   owed = 0;
	int   delay = 0;
	logic hold_out = 1'b0;

	tb_clock u_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mv_search_top DUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.c_pix      (c_pix),
		.p_pix      (p_pix),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.mv         (mv),
		.sad        (sad),
		.out_credit (out_credit)
	);

	task automatic show_mismatch(string name, int expected, int actual);
		errors++;
		$display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
	endtask

	task automatic raise_error(string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	task automatic end_test(string name);
		int n;
		n = errors - errors_at_start;
		tests_run++;
		if (n != 0) begin
			tests_failed++;
		end
		$display("%s: %s (%0d errors)", name, (n == 0) ? "pass" : "fail", n);
		errors_at_start = errors;
	endtask

	function automatic int abs_diff(int a, int b);
		return (a > b) ? a - b : b - a;
	endfunction

	task automatic fill_random_block();
		for (int k = 0; k < BEATS_PER_BLOCK; k++) begin
			cur_p[k] = pixel_t'($random(seed));
			if (k < BLOCK_PIXELS) begin
				cur_c[k] = pixel_t'($random(seed));
			end
		end
	endtask

	task automatic fill_flat(pixel_t cv, pixel_t pv);
		for (int k = 0; k < BEATS_PER_BLOCK; k++) begin
			cur_p[k] = pv;
			if (k < BLOCK_PIXELS) begin
				cur_c[k] = cv;
			end
		end
	endtask

	// full search over the current block where the first strict minimum wins
	task automatic queue_block();
		int sum;
		int best_sum;
		int best_d;
		best_sum = 0;
		best_d = 0;
		for (int d = 0; d < NUM_CAND; d++) begin
			sum = 0;
			for (int k = 0; k < BLOCK_PIXELS; k++) begin
				sum += abs_diff(int'(cur_c[k]), int'(cur_p[k + d]));
			end
			if (d == 0 || sum < best_sum) begin
				best_sum = sum;
				best_d = d;
			end
		end
		exp_mv.push_back(mv_t'(best_d));
		exp_sad.push_back(sad_t'(best_sum));
		for (int j = 0; j < BEATS_PER_BLOCK; j++) begin
			if (j < BLOCK_PIXELS) begin
				q_c.push_back(cur_c[j]);
			end else begin
				q_c.push_back(pixel_t'($random(seed)));
			end
			q_p.push_back(cur_p[j]);
		end
	endtask

	// polled on the falling edge, after all rising-edge updates have settled
	task automatic wait_idle();
		while (q_p.size() != 0 || exp_mv.size() != 0 || owed != 0) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	// source idles at random and only sends against a held credit
	always @(posedge clk) begin
		if (!arst_n) begin
			src_credits = IN_CREDITS;
			in_valid <= 1'b0;
		end else begin
			src_credits = src_credits + int'(in_credit);
			if (src_credits > 0 && q_p.size() != 0 && ($random(seed) & 3) != 0) begin
				in_valid <= 1'b1;
				c_pix <= q_c.pop_front();
				p_pix <= q_p.pop_front();
				src_credits = src_credits - 1;
				beats_sent++;
			end else begin
				in_valid <= 1'b0;
			end
		end
	end

	// sink hands each credit back after a random delay
	always @(posedge clk) begin
		out_credit <= 1'b0;
		if (arst_n) begin
			if (out_valid) begin
				owed++;
			end
			if (delay > 0) begin
				delay--;
			end else if (owed > 0 && !hold_out) begin
				out_credit <= 1'b1;
				owed--;
				delay = $random(seed) & 7;
			end
		end
	end

	// independent count of credits on the input side
	always @(posedge clk) begin
		if (arst_n) begin
			credit_pulses += int'(in_credit);
			mon_credits += int'(in_credit) - int'(in_valid);
			if (mon_credits < 0) begin
				raise_error("beat sent without an input credit");
			end
			if (mon_credits > IN_CREDITS) begin
				raise_error("more input credits returned than beats sent");
			end
		end
	end

	always @(posedge clk) begin
		if (arst_n && out_valid) begin
			results_seen++;
			assert (results_seen <= allowed_results)
				else raise_error("result sent without an output credit");
			if (exp_mv.size() == 0) begin
				raise_error("result with no block behind it");
			end else begin
				assert (mv == exp_mv[0])
					else show_mismatch("mv", int'(exp_mv[0]), int'(mv));
				assert (sad == exp_sad[0])
					else show_mismatch("sad", int'(exp_sad[0]), int'(sad));
				void'(exp_mv.pop_front());
				void'(exp_sad.pop_front());
			end
		end
	end

	a_quiet_start: assert property (@(posedge clk) disable iff (!arst_n)
		(beats_sent == 0) |-> (!out_valid && !in_credit))
		else raise_error("out_valid or in_credit active before the first beat");

	// a scan takes 16 cycles, so results never come back to back
	a_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |=> !out_valid)
		else raise_error("out_valid held for more than one cycle");

	initial begin
		wait (arst_n === 1'b1);
		repeat (8) @(posedge clk);
		end_test("reset_quiet");

		for (int i = 0; i < 4; i++) begin
			fill_random_block();
			for (int k = 0; k < BLOCK_PIXELS; k++) begin
				cur_p[k + planted[i]] = cur_c[k];
			end
			queue_block();
			assert (exp_sad[$] == 0 && exp_mv[$] == mv_t'(planted[i]))
				else raise_error("planted block has a better match elsewhere");
		end
		wait_idle();
		end_test("planted_match");

		for (int i = 0; i < 8; i++) begin
			fill_random_block();
			queue_block();
		end
		wait_idle();
		end_test("random_blocks");

		fill_flat(8'd7, 8'd19);
		queue_block();
		fill_flat(8'd255, 8'd0);
		queue_block();
		wait_idle();
		end_test("tie_extreme");

		// third result parks in the drain and the fourth block backs up the FIFO
		hold_out = 1'b1;
		allowed_results = results_seen + OUT_CREDITS;
		for (int i = 0; i < 4; i++) begin
			fill_random_block();
			queue_block();
		end
		while (!(results_seen == allowed_results && DUT.u_drain.state == SEND
				&& mon_credits == 0)) begin
			@(posedge clk);
		end
		assert (q_p.size() != 0) else raise_error("input did not stall under back-pressure");
		hold_out = 1'b0;
		allowed_results = 32'h7fffffff;
		wait_idle();
		end_test("back_pressure");

		assert (credit_pulses == beats_sent)
			else show_mismatch("in_credit pulses", beats_sent, credit_pulses);
		end_test("input_credits");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 4);
		$display("timeout after %0d cycles, results still pending", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- vlog.f
rtl/me_pkg.sv
rtl/pixel_feeder.sv
rtl/sad_pe.sv
rtl/best_match.sv
rtl/mv_search_top.sv
tb/tb_clock.sv
tb/tb_mv_search.sv
